/* Bender.yml */
package:
  name: cnn_top

sources:
  - rtl/cnn_hw_pkg.sv
  - rtl/cnn_layer_pkg.sv
  - rtl/network_sequencer.sv
  - rtl/data_loader.sv
  - rtl/layer_engine.sv
  - rtl/run_timer_display.sv
  - rtl/cnn_top.sv
  - target: test
    files:
      - verification/cnn_top_assertions.sv
      - verification/cnn_top_tb.sv

/* compile.f */
rtl/cnn_hw_pkg.sv
rtl/cnn_layer_pkg.sv
rtl/network_sequencer.sv
rtl/data_loader.sv
rtl/layer_engine.sv
rtl/run_timer_display.sv
rtl/cnn_top.sv
verification/cnn_top_assertions.sv
verification/cnn_top_tb.sv

/* rtl/cnn_hw_pkg.sv */
package cnn_hw_pkg;

	// one data word on the RAM write side
	localparam int unsigned DATA_WIDTH = 16; // fp16 word, contents not modelled

	// write address into the feature-map RAM and the weight RAM
	localparam int unsigned ADDR_WIDTH = 12; // 4k lines per RAM

	// feature-map geometry fields
	localparam int unsigned SIZE_WIDTH = 8; // fm_size, fm_size_out, fm_depth

	// word counts of a load and work counts of a layer run
	localparam int unsigned COUNT_WIDTH = 16;

	// board LEDs, one byte of the run count at a time
	localparam int unsigned LED_WIDTH = 8;

	// bytes shown on the LEDs, high to low
	localparam int unsigned LED_BYTES = 3; // 24-bit cycle counter

	// one RAM line holds PARA_Y words
	localparam int unsigned LINE_WIDTH_MAX = 4 * DATA_WIDTH; // widest line for PARA_Y up to 4

endpackage

/* rtl/cnn_layer_pkg.sv */
package cnn_layer_pkg;

	// layer type seen by the engine and the LEDs
	typedef enum logic [3:0] {
		lt_init = 4'd0, // initial feature-map load
		lt_conv = 4'd1,
		lt_pool = 4'd2, // max pool
		lt_fc   = 4'd3, // fully connected
		lt_done = 4'd9  // network finished
	} layer_type_t;

	// network sequencer states
	typedef enum logic [2:0] {
		s_idle, // waiting for transmission_start
		s_load, // loader busy
		s_run,  // engine busy
		s_next, // pick the next phase
		s_done
	} seq_state_t;

	localparam int unsigned LAYER_COUNT = 3; // conv, pool, fc

	// input feature map
	localparam int unsigned IN_SIZE  = 8;
	localparam int unsigned IN_DEPTH = 2;

	// conv layer, same padding
	localparam int unsigned CONV_KERNEL_SIZE = 3;
	localparam int unsigned CONV_KERNEL_NUM  = 4; // output depth
	localparam int unsigned CONV_OUT_SIZE    = 8;

	// 2x2 max pool
	localparam int unsigned POOL_OUT_SIZE = 4;

	// fully connected layer
	localparam int unsigned FC_IN_TOTAL = 64; // 4*4*4 flattened pool output
	localparam int unsigned FC_OUT      = 8;

endpackage

/* rtl/cnn_top.sv */
`timescale 1ns/1ps

module cnn_top import cnn_hw_pkg::*, cnn_layer_pkg::*; #(
	parameter int unsigned PARA_Y      = 2,
	parameter int unsigned PARA_KERNEL = 2,
	parameter int unsigned PHASE_WIDTH = 26 // about 0.17 s per LED byte at 100 MHz
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               transmission_start,
	output logic                               stop,
	output logic [LED_WIDTH-1:0]               led,
	output logic [$clog2(LAYER_COUNT + 2)-1:0] layer_num,
	output layer_type_t                        layer_type
);

	logic                   load_start; // sequencer to loader
	logic                   load_weights;
	logic [COUNT_WIDTH-1:0] load_words;
	logic                   load_done;
	logic                   layer_start; // sequencer to engine
	logic                   layer_done;
	logic [SIZE_WIDTH-1:0]  fm_size;
	logic [SIZE_WIDTH-1:0]  fm_size_out;
	logic [SIZE_WIDTH-1:0]  fm_depth;
	logic [SIZE_WIDTH-1:0]  kernel_num;
	logic [SIZE_WIDTH-1:0]  kernel_size;
	logic [COUNT_WIDTH-1:0] fm_total_size;
	logic                   fm_wr_en; // RAM write side, no RAM behind it
	logic [ADDR_WIDTH-1:0]  fm_wr_addr;
	logic                   wt_wr_en;
	logic [ADDR_WIDTH-1:0]  wt_wr_addr;

	network_sequencer #(.PARA_Y(PARA_Y), .PARA_KERNEL(PARA_KERNEL)) u_network_sequencer (
		.clk(clk), .rst(rst), .transmission_start(transmission_start),
		.load_done(load_done), .layer_done(layer_done),
		.load_start(load_start), .load_weights(load_weights), .load_words(load_words),
		.layer_start(layer_start), .layer_type(layer_type), .layer_num(layer_num),
		.fm_size(fm_size), .fm_size_out(fm_size_out), .fm_depth(fm_depth),
		.kernel_num(kernel_num), .kernel_size(kernel_size),
		.fm_total_size(fm_total_size), .stop(stop)
	);

	data_loader u_data_loader (
		.clk(clk), .rst(rst), .load_start(load_start),
		.load_weights(load_weights), .load_words(load_words),
		.fm_wr_en(fm_wr_en), .fm_wr_addr(fm_wr_addr),
		.wt_wr_en(wt_wr_en), .wt_wr_addr(wt_wr_addr), .load_done(load_done)
	);

	layer_engine #(.PARA_Y(PARA_Y), .PARA_KERNEL(PARA_KERNEL)) u_layer_engine (
		.clk(clk), .rst(rst), .layer_start(layer_start), .layer_type(layer_type),
		.fm_size(fm_size), .fm_size_out(fm_size_out), .fm_depth(fm_depth),
		.kernel_num(kernel_num), .kernel_size(kernel_size),
		.fm_total_size(fm_total_size), .layer_done(layer_done)
	);

	run_timer_display #(.PHASE_WIDTH(PHASE_WIDTH)) u_run_timer_display (
		.clk(clk), .rst(rst), .transmission_start(transmission_start),
		.stop(stop), .led(led)
	);

endmodule

/* rtl/data_loader.sv */
`timescale 1ns/1ps

module data_loader import cnn_hw_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   load_start,
	input  logic                   load_weights, // target RAM select
	input  logic [COUNT_WIDTH-1:0] load_words,
	output logic                   fm_wr_en,
	output logic [ADDR_WIDTH-1:0]  fm_wr_addr,
	output logic                   wt_wr_en,
	output logic [ADDR_WIDTH-1:0]  wt_wr_addr,
	output logic                   load_done
);

	logic [COUNT_WIDTH-1:0] remain; // words still to write
	logic                   to_wt; // latched target
	logic                   busy;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			remain     <= '0;
			to_wt      <= 1'b0;
			fm_wr_addr <= '0;
			wt_wr_addr <= '0;
		end else if (load_start) begin
			remain <= load_words;
			to_wt  <= load_weights;
			if (load_weights) wt_wr_addr <= '0; // restart target RAM at line 0
			else fm_wr_addr <= '0;
		end else if (busy) begin
			remain <= remain - 1'b1;
			if (to_wt) wt_wr_addr <= wt_wr_addr + 1'b1; // next line after each write
			else fm_wr_addr <= fm_wr_addr + 1'b1;
		end
	end

	assign busy      = (remain != '0);
	assign fm_wr_en  = busy && !to_wt;
	assign wt_wr_en  = busy && to_wt;
	assign load_done = (remain == COUNT_WIDTH'(1)); // same cycle as last write

endmodule

/* rtl/layer_engine.sv */
`timescale 1ns/1ps

module layer_engine import cnn_hw_pkg::*, cnn_layer_pkg::*; #(
	parameter int unsigned PARA_Y      = 2, // fc inputs per cycle
	parameter int unsigned PARA_KERNEL = 2  // conv kernels per cycle
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   layer_start,
	input  layer_type_t            layer_type,
	input  logic [SIZE_WIDTH-1:0]  fm_size,
	input  logic [SIZE_WIDTH-1:0]  fm_size_out,
	input  logic [SIZE_WIDTH-1:0]  fm_depth,
	input  logic [SIZE_WIDTH-1:0]  kernel_num,
	input  logic [SIZE_WIDTH-1:0]  kernel_size,
	input  logic [COUNT_WIDTH-1:0] fm_total_size,
	output logic                   layer_done
);

	logic [2*COUNT_WIDTH-1:0] conv_work; // wide products, cut below
	logic [2*COUNT_WIDTH-1:0] pool_work;
	logic [2*COUNT_WIDTH-1:0] fc_work;
	logic [COUNT_WIDTH-1:0]   work; // W for this layer
	logic [COUNT_WIDTH-1:0]   cnt; // cycles left

	// one output position per cycle, PARA_KERNEL kernels at once
	assign conv_work = fm_size_out * fm_size_out * kernel_num / PARA_KERNEL;
	// one pooled output per cycle over every channel
	assign pool_work = fm_size_out * fm_size_out * fm_depth;
	// each neuron takes PARA_Y inputs per cycle
	assign fc_work   = kernel_num * fm_total_size / PARA_Y;

	always_comb begin
		case (layer_type)
			lt_conv: begin
				if (kernel_size > fm_size) work = COUNT_WIDTH'(1); // window never fits
				else work = conv_work[COUNT_WIDTH-1:0];
			end
			lt_pool: work = pool_work[COUNT_WIDTH-1:0];
			lt_fc:   work = fc_work[COUNT_WIDTH-1:0];
			default: work = COUNT_WIDTH'(1); // nothing to compute
		endcase
		if (work == '0) work = COUNT_WIDTH'(1); // W at least 1
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) cnt <= '0;
		else if (layer_start) cnt <= work;
		else if (cnt != '0) cnt <= cnt - 1'b1;
	end

	assign layer_done = (cnt == COUNT_WIDTH'(1)); // W cycles after start

endmodule

/* rtl/network_sequencer.sv */
`timescale 1ns/1ps

module network_sequencer import cnn_hw_pkg::*, cnn_layer_pkg::*; #(
	parameter int unsigned PARA_Y      = 2, // words per RAM line
	parameter int unsigned PARA_KERNEL = 2  // kernels per engine pass
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                transmission_start,
	input  logic                                load_done,
	input  logic                                layer_done,
	output logic                                load_start,
	output logic                                load_weights, // 0 fm words, 1 weight words
	output logic [COUNT_WIDTH-1:0]              load_words,
	output logic                                layer_start,
	output layer_type_t                         layer_type,
	output logic [$clog2(LAYER_COUNT + 2)-1:0]  layer_num,
	output logic [SIZE_WIDTH-1:0]               fm_size,
	output logic [SIZE_WIDTH-1:0]               fm_size_out,
	output logic [SIZE_WIDTH-1:0]               fm_depth,
	output logic [SIZE_WIDTH-1:0]               kernel_num,
	output logic [SIZE_WIDTH-1:0]               kernel_size,
	output logic [COUNT_WIDTH-1:0]              fm_total_size,
	output logic                                stop
);

	// weight RAM is laid out in groups of PARA_KERNEL kernels
	localparam int unsigned CONV_KERNEL_PAD =
		(CONV_KERNEL_NUM + PARA_KERNEL - 1) / PARA_KERNEL * PARA_KERNEL;
	localparam int unsigned FM_WORDS = IN_SIZE * IN_SIZE * IN_DEPTH / PARA_Y;
	localparam int unsigned CONV_WT_WORDS =
		CONV_KERNEL_SIZE * CONV_KERNEL_SIZE * IN_DEPTH * CONV_KERNEL_PAD / PARA_Y;
	localparam int unsigned FC_WT_WORDS = FC_IN_TOTAL * FC_OUT / PARA_Y;

	seq_state_t state;
	logic [2:0] phase; // index of the phase that is running
	logic       workstate; // transmission_start, one cycle late

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) workstate <= 1'b0;
		else workstate <= transmission_start;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) stop <= 1'b0;
		else if (layer_type == lt_done) stop <= 1'b1; // sticky until reset
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state         <= s_idle;
			phase         <= 3'd0;
			load_start    <= 1'b0;
			load_weights  <= 1'b0;
			load_words    <= '0;
			layer_start   <= 1'b0;
			layer_type    <= lt_init;
			layer_num     <= '0;
			fm_size       <= '0;
			fm_size_out   <= '0;
			fm_depth      <= '0;
			kernel_num    <= '0;
			kernel_size   <= '0;
			fm_total_size <= '0;
		end else begin
			load_start  <= 1'b0; // pulses
			layer_start <= 1'b0;
			case (state)
				s_idle: if (workstate) begin
					load_start   <= 1'b1; // input feature map first
					load_weights <= 1'b0;
					load_words   <= COUNT_WIDTH'(FM_WORDS);
					phase        <= 3'd0;
					state        <= s_load;
				end
				s_load: if (load_done) state <= s_next; // done pulse never missed, even paused
				s_run: if (layer_done) state <= s_next;
				s_next: if (workstate) begin
					phase <= phase + 3'd1;
					case (phase)
						3'd0: begin // conv config, then its weights
							layer_type    <= lt_conv;
							layer_num     <= layer_num + 1'b1;
							fm_size       <= SIZE_WIDTH'(IN_SIZE);
							fm_depth      <= SIZE_WIDTH'(IN_DEPTH);
							fm_size_out   <= SIZE_WIDTH'(CONV_OUT_SIZE);
							kernel_num    <= SIZE_WIDTH'(CONV_KERNEL_NUM);
							kernel_size   <= SIZE_WIDTH'(CONV_KERNEL_SIZE);
							fm_total_size <= COUNT_WIDTH'(IN_SIZE * IN_SIZE * IN_DEPTH);
							load_start    <= 1'b1;
							load_weights  <= 1'b1;
							load_words    <= COUNT_WIDTH'(CONV_WT_WORDS);
							state         <= s_load;
						end
						3'd1, 3'd4: begin // weights in place, run the layer
							layer_start <= 1'b1;
							state       <= s_run;
						end
						3'd2: begin // pool needs no weights
							layer_type    <= lt_pool;
							layer_num     <= layer_num + 1'b1;
							fm_size       <= SIZE_WIDTH'(CONV_OUT_SIZE);
							fm_depth      <= SIZE_WIDTH'(CONV_KERNEL_NUM);
							fm_size_out   <= SIZE_WIDTH'(POOL_OUT_SIZE);
							fm_total_size <= COUNT_WIDTH'(CONV_OUT_SIZE * CONV_OUT_SIZE * CONV_KERNEL_NUM);
							layer_start   <= 1'b1;
							state         <= s_run;
						end
						3'd3: begin // fc config, then its weights
							layer_type    <= lt_fc;
							layer_num     <= layer_num + 1'b1;
							fm_size       <= SIZE_WIDTH'(POOL_OUT_SIZE);
							fm_depth      <= SIZE_WIDTH'(CONV_KERNEL_NUM);
							fm_size_out   <= SIZE_WIDTH'(1); // 1x1 output per neuron
							kernel_num    <= SIZE_WIDTH'(FC_OUT);
							kernel_size   <= SIZE_WIDTH'(1);
							fm_total_size <= COUNT_WIDTH'(FC_IN_TOTAL);
							load_start    <= 1'b1;
							load_weights  <= 1'b1;
							load_words    <= COUNT_WIDTH'(FC_WT_WORDS);
							state         <= s_load;
						end
						default: begin // last layer finished
							layer_type <= lt_done;
							layer_num  <= layer_num + 1'b1;
							state      <= s_done;
						end
					endcase
				end
				default: state <= s_done; // s_done holds until reset
			endcase
		end
	end

endmodule

/* rtl/run_timer_display.sv */
`timescale 1ns/1ps

module run_timer_display import cnn_hw_pkg::*; #(
	parameter int unsigned PHASE_WIDTH = 26 // log2 of the LED cycle
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 transmission_start,
	input  logic                 stop,
	output logic [LED_WIDTH-1:0] led
);

	localparam int unsigned CNT_WIDTH = LED_BYTES * LED_WIDTH; // 24-bit run count

	logic                   run_en; // registered transmission_start
	logic [CNT_WIDTH-1:0]   clk_cnt;
	logic [PHASE_WIDTH-1:0] phase_cnt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			run_en    <= 1'b0;
			clk_cnt   <= '0;
			phase_cnt <= '0;
			led       <= '0;
		end else begin
			run_en <= transmission_start;
			if (run_en && !stop) clk_cnt <= clk_cnt + 1'b1; // frozen once stop is up
			if (stop) phase_cnt <= phase_cnt + 1'b1;
			case (phase_cnt[PHASE_WIDTH-1 -: 2]) // blank, high, mid, low
				2'b00: led <= '0;
				2'b01: led <= clk_cnt[3*LED_WIDTH-1 -: LED_WIDTH];
				2'b10: led <= clk_cnt[2*LED_WIDTH-1 -: LED_WIDTH];
				default: led <= clk_cnt[LED_WIDTH-1:0];
			endcase
		end
	end

endmodule

/* verification/cnn_top_assertions.sv */
`timescale 1ns/1ps

module cnn_top_assertions (
	input logic clk,
	input logic rst,
	input logic load_start,
	input logic layer_start,
	input logic stop
);

	int fail_count = 0; // read by the testbench at the end

	// start commands are one-cycle pulses
	load_start_pulse: assert property (
		@(posedge clk) disable iff (!rst) load_start |=> !load_start
	) else begin
		fail_count++;
		$error("load_start high for more than one cycle");
	end

	layer_start_pulse: assert property (
		@(posedge clk) disable iff (!rst) layer_start |=> !layer_start
	) else begin
		fail_count++;
		$error("layer_start high for more than one cycle");
	end

	// loader and engine never started together
	start_exclusive: assert property (
		@(posedge clk) disable iff (!rst) !(load_start && layer_start)
	) else begin
		fail_count++;
		$error("load_start and layer_start high together");
	end

	// stop is sticky until reset
	stop_sticky: assert property (
		@(posedge clk) disable iff (!rst) stop |=> stop
	) else begin
		fail_count++;
		$error("stop fell without reset");
	end

endmodule

bind network_sequencer cnn_top_assertions u_cnn_top_assertions (
	.clk(clk), .rst(rst), .load_start(load_start), .layer_start(layer_start), .stop(stop)
);

/* verification/cnn_top_tb.sv */
`timescale 1ns/1ps

module cnn_top_tb import cnn_layer_pkg::*;;

	localparam int PARA_Y      = 2;
	localparam int PARA_KERNEL = 2;
	localparam int PHASE_WIDTH = 4; // short LED phases for simulation

	// phase lengths of the fixed network
	localparam int FM_WORDS  = IN_SIZE * IN_SIZE * IN_DEPTH / PARA_Y;
	localparam int CONV_WT   =
		CONV_KERNEL_SIZE * CONV_KERNEL_SIZE * IN_DEPTH * CONV_KERNEL_NUM / PARA_Y;
	localparam int CONV_RUN  = CONV_OUT_SIZE * CONV_OUT_SIZE * CONV_KERNEL_NUM / PARA_KERNEL;
	localparam int POOL_RUN  = POOL_OUT_SIZE * POOL_OUT_SIZE * CONV_KERNEL_NUM;
	localparam int FC_WT     = FC_IN_TOTAL * FC_OUT / PARA_Y;
	localparam int FC_RUN    = FC_OUT * FC_IN_TOTAL / PARA_Y;
	localparam int PHASE_LEN [6] = '{FM_WORDS, CONV_WT, CONV_RUN, POOL_RUN, FC_WT, FC_RUN};
	localparam int RUN_COUNT =
		FM_WORDS + CONV_WT + CONV_RUN + POOL_RUN + FC_WT + FC_RUN + 2 * 6 + 2;

	localparam int LED_HOLD   = 2 ** (PHASE_WIDTH - 2); // cycles per LED value
	localparam int LED_PERIOD = 4 * LED_HOLD; // blank, high, mid, low
	localparam int MAX_PAUSE  = 18;
	localparam int TIMEOUT_CYCLES = 4 * (3 * (RUN_COUNT + 2 * LED_PERIOD + 16) + MAX_PAUSE);
	localparam layer_type_t LAYER_ORDER [5] = '{lt_init, lt_conv, lt_pool, lt_fc, lt_done};

	logic        clk;
	logic        rst;
	logic        transmission_start;
	logic        stop;
	logic [7:0]  led;
	logic [2:0]  layer_num;
	layer_type_t layer_type;

	int checks;
	int errors;
	int cycle_count;

	cnn_top #(.PARA_Y(PARA_Y), .PARA_KERNEL(PARA_KERNEL), .PHASE_WIDTH(PHASE_WIDTH)) u_cnn_top (
		.clk(clk), .rst(rst), .transmission_start(transmission_start),
		.stop(stop), .led(led), .layer_num(layer_num), .layer_type(layer_type)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Error: simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	// first edge of phase k, counted from the edge that raised transmission_start, minus two
	function automatic int phase_start(input int k);
		int sum;
		sum = 0;
		for (int j = 0; j < k; j++) sum += PHASE_LEN[j] + 2;
		return sum;
	endfunction

	function automatic logic [7:0] led_byte(input int sel);
		case (sel)
			1: return 8'((RUN_COUNT >> 16) & 'hff); // high byte
			2: return 8'((RUN_COUNT >> 8) & 'hff);
			3: return 8'(RUN_COUNT & 'hff);
			default: return 8'h00; // blank phase
		endcase
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		rst                <= 1'b0;
		transmission_start <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("stop", stop, 1'b0);
			check_value("led", led, 8'h00);
			check_value("layer_num", layer_num, 3'd0);
			check_value("layer_type", layer_type, lt_init);
		end
	endtask

	// starts one inference, optional pause, returns at the negedge where stop is first high
	task automatic run_network(input int pause_at, input int pause_len);
		int          n;
		int          fm_writes;
		int          wt_writes;
		logic        stop_seen;
		logic [2:0]  held_num;
		layer_type_t type_q[$];
		int          num_q[$];
		n         = 0;
		fm_writes = 0;
		wt_writes = 0;
		stop_seen = 1'b0;
		held_num  = '0;
		type_q.push_back(layer_type);
		num_q.push_back(layer_num);
		@(posedge clk);
		transmission_start <= 1'b1; // edge 0
		while (!stop_seen) begin
			@(posedge clk);
			n++;
			if (pause_len > 0 && n == pause_at) transmission_start <= 1'b0;
			if (pause_len > 0 && n == pause_at + pause_len) transmission_start <= 1'b1;
			@(negedge clk);
			if (pause_len > 0 && n == pause_at) held_num = layer_num;
			if (pause_len > 0 && n > pause_at && n <= pause_at + pause_len)
				check_value("layer_num", layer_num, held_num); // sequencer frozen
			if (layer_type != type_q[$] || layer_num != num_q[$]) begin
				type_q.push_back(layer_type);
				num_q.push_back(layer_num);
			end
			if (u_cnn_top.fm_wr_en) begin // single input load from line 0
				check_value("fm_wr_addr", u_cnn_top.fm_wr_addr, fm_writes);
				fm_writes++;
			end
			if (u_cnn_top.wt_wr_en) begin
				check_value("wt_wr_addr", u_cnn_top.wt_wr_addr,
					(wt_writes < CONV_WT) ? wt_writes : wt_writes - CONV_WT); // fc restarts at 0
				wt_writes++;
			end
			if (stop) stop_seen = 1'b1;
		end
		check_value("stop rise cycle", n, RUN_COUNT + 1 + pause_len);
		check_value("fm write count", fm_writes, FM_WORDS);
		check_value("wt write count", wt_writes, CONV_WT + FC_WT);
		check_value("layer step count", type_q.size(), 5);
		foreach (LAYER_ORDER[i]) begin
			if (i < type_q.size()) begin
				check_value("layer_type", type_q[i], LAYER_ORDER[i]);
				check_value("layer_num", num_q[i], i);
			end
		end
	endtask

	task automatic check_led_display(input int periods);
		for (int j = 0; j < periods * LED_PERIOD; j++) begin
			@(posedge clk);
			@(negedge clk);
			check_value("led", led, led_byte((j / LED_HOLD) % 4));
		end
	endtask

	task automatic test_reset_state();
		check_idle(5);
	endtask

	task automatic test_full_run();
		run_network(0, 0);
		check_led_display(2); // sequence repeats
	endtask

	task automatic test_second_run();
		repeat (6) @(posedge clk); // somewhere in the display
		rst                <= 1'b0;
		transmission_start <= 1'b0;
		@(negedge clk);
		check_value("stop", stop, 1'b0); // async clear
		check_value("led", led, 8'h00);
		repeat (7) @(posedge clk);
		rst <= 1'b1;
		check_idle(3);
		run_network(0, 0);
		check_led_display(1);
	endtask

	task automatic test_pause();
		int k;
		int len;
		k   = 1 + ($urandom % 5); // pause in front of phase 1..5
		len = 3 + ($urandom % (MAX_PAUSE - 2));
		apply_reset();
		check_idle(3);
		run_network(phase_start(k), len);
		check_led_display(2); // paused cycles not counted
	endtask

	initial begin
		checks             = 0;
		errors             = 0;
		cycle_count        = 0;
		void'($urandom(19));
		rst                = 1'b0;
		transmission_start = 1'b0;
		apply_reset();
		test_reset_state();
		test_full_run();
		test_second_run();
		test_pause();
		errors += u_cnn_top.u_network_sequencer.u_cnn_top_assertions.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
